// File: source/slot_buffer_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Slot table is fixed at build time. Every slot must fit below MEM_BYTES
////////////////////////////////////////////////////////////////////////////
package slot_buffer_pkg;

  localparam int DATA_WIDTH      = 64;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int ADDR_WIDTH      = 16;
  localparam int MEM_BYTES       = 32768;
  localparam int LINE_ADDR_BITS  = $clog2(STRB_WIDTH);
  localparam int LINE_ADDR_WIDTH = $clog2(MEM_BYTES) - LINE_ADDR_BITS;
  localparam int SLOT_COUNT      = 8;
  localparam int SLOT_WIDTH      = $clog2(SLOT_COUNT);
  localparam int PORT_WIDTH      = 2;
  localparam int LEN_WIDTH       = 16;
  localparam int LINE_CNT_WIDTH  = LEN_WIDTH - LINE_ADDR_BITS + 1;
  localparam int DESC_FIFO_DEPTH = 8;

  localparam logic [ADDR_WIDTH-1:0] SLOT_START_ADDR = 16'h2000;
  localparam logic [ADDR_WIDTH-1:0] SLOT_ADDR_STEP  = 16'h0800;

  // Write and read operation codes are bitwise inverse
  localparam logic [1:0] MEM_IDLE  = 2'b00;
  localparam logic [1:0] MEM_WRITE = 2'b01;
  localparam logic [1:0] MEM_READ  = 2'b10;

  // Descriptor word as seen on the control streams
  typedef struct packed {
    logic [15:0]             rsvd_top;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [7-PORT_WIDTH:0]   rsvd_port;
    logic [PORT_WIDTH-1:0]   port;
    logic [7-SLOT_WIDTH:0]   rsvd_slot;
    logic [SLOT_WIDTH-1:0]   slot;
    logic [LEN_WIDTH-1:0]    len;
  } desc_t;

  function automatic logic [ADDR_WIDTH-1:0] slot_base(input logic [SLOT_WIDTH-1:0] slot);
    return SLOT_START_ADDR + ADDR_WIDTH'(slot) * SLOT_ADDR_STEP;
  endfunction

endpackage

// File: source/mem_port_if.sv
////////////////////////////////////////////////////////////////////////////
// Grant comes back in the request cycle, read data one cycle after
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface mem_port_if import slot_buffer_pkg::*; ();

  logic                       req;
  logic                       we;
  logic [LINE_ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0]      wdata;
  logic [STRB_WIDTH-1:0]      strb;
  logic                       last;
  logic                       gnt;
  logic [DATA_WIDTH-1:0]      rdata;
  logic                       rvalid;

  modport requester (
    output req, we, addr, wdata, strb, last,
    input  gnt, rdata, rvalid
  );

  modport memory (
    input  req, we, addr, wdata, strb, last,
    output gnt, rdata, rvalid
  );

endinterface

// File: source/desc_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Register based FIFO with output valid one cycle after the push
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module desc_fifo import slot_buffer_pkg::*; #(
  parameter type T = desc_t
) (
  input  logic sys_clk,
  input  logic sys_rst,
  input  T     in_data,
  input  logic in_valid,
  output logic in_ready,
  output T     out_data,
  output logic out_valid,
  input  logic out_ready
);

  localparam int PTR_WIDTH = $clog2(DESC_FIFO_DEPTH);

  T                   entries [DESC_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 push;
  logic                 pop;

  assign in_ready  = (count != (PTR_WIDTH+1)'(DESC_FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = entries[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge sys_clk) begin
    if (push) begin
      entries[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_WIDTH+1)'(push) - (PTR_WIDTH+1)'(pop);
    end
  end

  // Pointers meet whenever the FIFO is full or empty
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    !in_ready |-> wr_ptr == rd_ptr);
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    !out_valid |-> wr_ptr == rd_ptr);

endmodule

// File: source/ingress_writer.sv
////////////////////////////////////////////////////////////////////////////
// Expects contiguous tkeep, partial bytes only on the last beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ingress_writer import slot_buffer_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic [STRB_WIDTH-1:0] s_tkeep,
  input  logic                  s_tvalid,
  input  logic                  s_tlast,
  input  logic [SLOT_WIDTH-1:0] s_tdest,
  input  logic [PORT_WIDTH-1:0] s_tuser,
  output logic                  s_tready,
  mem_port_if.requester         mem,
  output desc_t                 desc_data,
  output logic                  desc_valid,
  input  logic                  desc_ready
);

  logic [LINE_ADDR_WIDTH-1:0] beat_cnt;
  logic [LEN_WIDTH-1:0]       len_r;
  logic [LEN_WIDTH-1:0]       len_next;
  logic [SLOT_WIDTH-1:0]      slot_r;
  logic [PORT_WIDTH-1:0]      port_r;
  logic [ADDR_WIDTH-1:0]      base_addr;
  logic                       first_hold;
  logic                       beat;

  // A new packet waits while the previous descriptor is still stuck
  assign first_hold = (beat_cnt == '0) && desc_valid && !desc_ready;
  assign base_addr  = slot_base(s_tdest);

  assign mem.req   = s_tvalid && !first_hold;
  assign mem.we    = 1'b1;
  assign mem.addr  = base_addr[LINE_ADDR_BITS +: LINE_ADDR_WIDTH] + beat_cnt;
  assign mem.wdata = s_tdata;
  assign mem.strb  = s_tkeep;
  assign mem.last  = s_tlast;

  assign s_tready = mem.gnt;
  assign beat     = s_tvalid && s_tready;
  assign len_next = ((beat_cnt == '0) ? '0 : len_r) + LEN_WIDTH'($countones(s_tkeep));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      beat_cnt   <= '0;
      desc_valid <= 1'b0;
    end else begin
      if (beat) beat_cnt <= s_tlast ? '0 : beat_cnt + 1'b1;
      if (beat && s_tlast)  desc_valid <= 1'b1;
      else if (desc_ready)  desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (beat) begin
      len_r  <= len_next;
      slot_r <= s_tdest;
      port_r <= s_tuser;
    end
  end

  always_comb begin
    desc_data      = '0;
    desc_data.addr = slot_base(slot_r);
    desc_data.port = port_r;
    desc_data.slot = slot_r;
    desc_data.len  = len_r;
  end

  // Only the last beat may be partial
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    s_tvalid && !s_tlast |-> &s_tkeep);

endmodule

// File: source/egress_reader.sv
////////////////////////////////////////////////////////////////////////////
// One descriptor at a time; a zero length descriptor is not supported
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module egress_reader import slot_buffer_pkg::*; (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  desc_t                 desc_data,
  input  logic                  desc_valid,
  output logic                  desc_ready,
  mem_port_if.requester         mem,
  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic [STRB_WIDTH-1:0] m_tkeep,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  output logic [PORT_WIDTH-1:0] m_tdest,
  output logic [SLOT_WIDTH-1:0] m_tuser,
  input  logic                  m_tready,
  output desc_t                 sent_data,
  output logic                  sent_valid,
  input  logic                  sent_ready
);

  desc_t                      desc_r;
  logic                       busy;
  logic [LEN_WIDTH:0]         len_round;
  logic [LINE_CNT_WIDTH-1:0]  desc_lines;
  logic [LINE_CNT_WIDTH-1:0]  rd_left;
  logic [LINE_CNT_WIDTH-1:0]  out_left;
  logic [LINE_ADDR_WIDTH-1:0] rd_addr;
  logic [1:0]                 credit;
  logic                       rd_issue;
  logic [DATA_WIDTH-1:0]      buf_data [2];
  logic                       buf_wr_ptr;
  logic                       buf_rd_ptr;
  logic [1:0]                 buf_cnt;
  logic                       pop;
  logic [LINE_ADDR_BITS-1:0]  tail_bytes;

  assign len_round  = {1'b0, desc_data.len} + (LEN_WIDTH+1)'(STRB_WIDTH - 1);
  assign desc_lines = len_round[LEN_WIDTH:LINE_ADDR_BITS];
  assign desc_ready = !busy && !sent_valid;

  // Credit counts buffered beats plus reads still in flight
  assign mem.req   = busy && (rd_left != '0) && (credit < 2'd2);
  assign mem.we    = 1'b0;
  assign mem.addr  = rd_addr;
  assign mem.wdata = '0;
  assign mem.strb  = '0;
  assign mem.last  = (rd_left == LINE_CNT_WIDTH'(1));
  assign rd_issue  = mem.req && mem.gnt;

  assign tail_bytes = desc_r.len[LINE_ADDR_BITS-1:0];
  assign m_tvalid   = (buf_cnt != '0);
  assign m_tdata    = buf_data[buf_rd_ptr];
  assign m_tlast    = (out_left == LINE_CNT_WIDTH'(1));
  assign m_tkeep    = (m_tlast && tail_bytes != '0) ? ~({STRB_WIDTH{1'b1}} << tail_bytes)
                                                     : {STRB_WIDTH{1'b1}};
  assign m_tdest    = desc_r.port;
  assign m_tuser    = desc_r.slot;
  assign pop        = m_tvalid && m_tready;
  assign sent_data  = desc_r;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      busy       <= 1'b0;
      rd_left    <= '0;
      out_left   <= '0;
      credit     <= '0;
      buf_wr_ptr <= 1'b0;
      buf_rd_ptr <= 1'b0;
      buf_cnt    <= '0;
      sent_valid <= 1'b0;
    end else begin
      if (desc_valid && desc_ready) begin
        busy     <= 1'b1;
        rd_left  <= desc_lines;
        out_left <= desc_lines;
      end
      if (rd_issue) rd_left <= rd_left - 1'b1;
      if (pop)      out_left <= out_left - 1'b1;
      if (pop && m_tlast) busy <= 1'b0;
      credit <= credit + 2'(rd_issue) - 2'(pop);
      if (mem.rvalid) buf_wr_ptr <= ~buf_wr_ptr;
      if (pop)        buf_rd_ptr <= ~buf_rd_ptr;
      buf_cnt <= buf_cnt + 2'(mem.rvalid) - 2'(pop);
      // Echo follows the transfer of the final beat
      if (pop && m_tlast)  sent_valid <= 1'b1;
      else if (sent_ready) sent_valid <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (desc_valid && desc_ready) begin
      desc_r  <= desc_data;
      rd_addr <= desc_data.addr[LINE_ADDR_BITS +: LINE_ADDR_WIDTH];
    end else if (rd_issue) begin
      rd_addr <= rd_addr + 1'b1;
    end
    if (mem.rvalid) buf_data[buf_wr_ptr] <= mem.rdata;
  end

  // Stalled beat holds until taken
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

// File: source/packet_mem.sv
////////////////////////////////////////////////////////////////////////////
// Single port, so a cycle carries either one write or one read
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module packet_mem import slot_buffer_pkg::*; #(
  parameter bit INTERLEAVE = 1'b1
) (
  input  logic          sys_clk,
  input  logic          sys_rst,
  mem_port_if.memory    wr,
  mem_port_if.memory    rd
);

  logic [DATA_WIDTH-1:0]      lines [MEM_BYTES / STRB_WIDTH];
  logic [DATA_WIDTH-1:0]      rdata_q;
  logic [LINE_ADDR_WIDTH-1:0] line_addr;
  logic [1:0]                 op;
  logic [1:0]                 last_op;
  logic                       burst_switch;
  logic                       rvalid_q;
  logic                       wr_en;
  logic                       rd_en;

  assign wr_en = wr.req && wr.we;
  assign rd_en = rd.req && !rd.we;

  //////////////////////////////////////////////////////////////////////////
  // Write/read arbiter

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      last_op      <= MEM_IDLE;
      burst_switch <= 1'b0;
    end else begin
      last_op      <= op;
      burst_switch <= ((op == MEM_WRITE) && wr.last) || ((op == MEM_READ) && rd.last);
    end
  end

  always_comb begin
    case ({wr_en, rd_en})
      2'b00:   op = MEM_IDLE;
      2'b01:   op = MEM_READ;
      2'b10:   op = MEM_WRITE;
      default: begin
        // Coming out of idle the write goes first
        if (last_op == MEM_IDLE)
          op = MEM_WRITE;
        else if (INTERLEAVE || burst_switch)
          op = ~last_op;
        else
          op = last_op;
      end
    endcase
  end

  assign wr.gnt = (op == MEM_WRITE);
  assign rd.gnt = (op == MEM_READ);

  //////////////////////////////////////////////////////////////////////////
  // Line array

  assign line_addr = (op == MEM_WRITE) ? wr.addr : rd.addr;

  always_ff @(posedge sys_clk) begin
    if (op == MEM_WRITE) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (wr.strb[b]) lines[line_addr][b*8 +: 8] <= wr.wdata[b*8 +: 8];
      end
    end
    if (op == MEM_READ) rdata_q <= lines[line_addr];
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) rvalid_q <= 1'b0;
    else         rvalid_q <= (op == MEM_READ);
  end

  assign rd.rdata  = rdata_q;
  assign rd.rvalid = rvalid_q;
  assign wr.rdata  = rdata_q;
  assign wr.rvalid = 1'b0;

  // In interleaved mode a waiting request never loses twice in a row
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    INTERLEAVE && wr_en && !wr.gnt |=> !wr_en || wr.gnt);
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    INTERLEAVE && rd_en && !rd.gnt |=> !rd_en || rd.gnt);

endmodule

// File: source/ctrl_port.sv
////////////////////////////////////////////////////////////////////////////
// Sent echoes always win over receive descriptors on the output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_port import slot_buffer_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  desc_t ctrl_s_tdata,
  input  logic  ctrl_s_tvalid,
  output logic  ctrl_s_tready,
  output desc_t ctrl_m_tdata,
  output logic  ctrl_m_tvalid,
  input  logic  ctrl_m_tready,
  input  desc_t recv_data,
  input  logic  recv_valid,
  output logic  recv_ready,
  output desc_t send_data,
  output logic  send_valid,
  input  logic  send_ready,
  input  desc_t sent_data,
  input  logic  sent_valid,
  output logic  sent_ready
);

  desc_t recv_q_data;
  logic  recv_q_valid;
  logic  recv_q_ready;
  desc_t sent_q_data;
  logic  sent_q_valid;
  logic  sent_q_ready;
  logic  pick_sent;

  // Send descriptors from the scheduler
  desc_fifo #(.T(desc_t)) u_ctrl_in_fifo (
    .sys_clk, .sys_rst,
    .in_data(ctrl_s_tdata), .in_valid(ctrl_s_tvalid), .in_ready(ctrl_s_tready),
    .out_data(send_data), .out_valid(send_valid), .out_ready(send_ready)
  );

  desc_fifo #(.T(desc_t)) u_recv_fifo (
    .sys_clk, .sys_rst,
    .in_data(recv_data), .in_valid(recv_valid), .in_ready(recv_ready),
    .out_data(recv_q_data), .out_valid(recv_q_valid), .out_ready(recv_q_ready)
  );

  desc_fifo #(.T(desc_t)) u_sent_fifo (
    .sys_clk, .sys_rst,
    .in_data(sent_data), .in_valid(sent_valid), .in_ready(sent_ready),
    .out_data(sent_q_data), .out_valid(sent_q_valid), .out_ready(sent_q_ready)
  );

  // Priority merge where the release of a slot goes first
  assign pick_sent     = sent_q_valid;
  assign ctrl_m_tvalid = sent_q_valid || recv_q_valid;
  assign ctrl_m_tdata  = pick_sent ? sent_q_data : recv_q_data;
  assign sent_q_ready  = ctrl_m_tready && pick_sent;
  assign recv_q_ready  = ctrl_m_tready && !pick_sent;

endmodule

// File: source/slot_buffer_top.sv
////////////////////////////////////////////////////////////////////////////
// Control words are desc_t; slot addresses come from the fixed table
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module slot_buffer_top import slot_buffer_pkg::*; #(
  parameter bit INTERLEAVE = 1'b1
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  // Incoming data
  input  logic [DATA_WIDTH-1:0] data_s_tdata,
  input  logic [STRB_WIDTH-1:0] data_s_tkeep,
  input  logic                  data_s_tvalid,
  output logic                  data_s_tready,
  input  logic                  data_s_tlast,
  input  logic [SLOT_WIDTH-1:0] data_s_tdest,
  input  logic [PORT_WIDTH-1:0] data_s_tuser,
  // Outgoing data
  output logic [DATA_WIDTH-1:0] data_m_tdata,
  output logic [STRB_WIDTH-1:0] data_m_tkeep,
  output logic                  data_m_tvalid,
  input  logic                  data_m_tready,
  output logic                  data_m_tlast,
  output logic [PORT_WIDTH-1:0] data_m_tdest,
  output logic [SLOT_WIDTH-1:0] data_m_tuser,
  // Control in and out
  input  logic [DATA_WIDTH-1:0] ctrl_s_tdata,
  input  logic                  ctrl_s_tvalid,
  output logic                  ctrl_s_tready,
  output logic [DATA_WIDTH-1:0] ctrl_m_tdata,
  output logic                  ctrl_m_tvalid,
  input  logic                  ctrl_m_tready
);

  desc_t recv_data;
  logic  recv_valid;
  logic  recv_ready;
  desc_t send_data;
  logic  send_valid;
  logic  send_ready;
  desc_t sent_data;
  logic  sent_valid;
  logic  sent_ready;

  mem_port_if wr_port ();
  mem_port_if rd_port ();

  ingress_writer u_ingress (
    .sys_clk, .sys_rst,
    .s_tdata(data_s_tdata), .s_tkeep(data_s_tkeep), .s_tvalid(data_s_tvalid),
    .s_tlast(data_s_tlast), .s_tdest(data_s_tdest), .s_tuser(data_s_tuser),
    .s_tready(data_s_tready), .mem(wr_port.requester),
    .desc_data(recv_data), .desc_valid(recv_valid), .desc_ready(recv_ready)
  );

  egress_reader u_egress (
    .sys_clk, .sys_rst,
    .desc_data(send_data), .desc_valid(send_valid), .desc_ready(send_ready),
    .mem(rd_port.requester),
    .m_tdata(data_m_tdata), .m_tkeep(data_m_tkeep), .m_tvalid(data_m_tvalid),
    .m_tlast(data_m_tlast), .m_tdest(data_m_tdest), .m_tuser(data_m_tuser),
    .m_tready(data_m_tready),
    .sent_data(sent_data), .sent_valid(sent_valid), .sent_ready(sent_ready)
  );

  packet_mem #(.INTERLEAVE(INTERLEAVE)) u_mem (
    .sys_clk, .sys_rst, .wr(wr_port.memory), .rd(rd_port.memory)
  );

  ctrl_port u_ctrl (
    .sys_clk, .sys_rst,
    .ctrl_s_tdata(desc_t'(ctrl_s_tdata)), .ctrl_s_tvalid, .ctrl_s_tready,
    .ctrl_m_tdata, .ctrl_m_tvalid, .ctrl_m_tready,
    .recv_data, .recv_valid, .recv_ready,
    .send_data, .send_valid, .send_ready,
    .sent_data, .sent_valid, .sent_ready
  );

endmodule

// File: testbench/tb_slot_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Checks run at transfers against reference queues; INTERLEAVE = 1 only
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_slot_buffer import slot_buffer_pkg::*; ();

  localparam int SEED     = 32'h2075;
  localparam int NUM_PKTS = 12;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] keep;
    logic                  last;
    logic [PORT_WIDTH-1:0] dest;
    logic [SLOT_WIDTH-1:0] user;
  } beat_t;

  logic                  sys_clk;
  logic                  sys_rst;
  logic [DATA_WIDTH-1:0] data_s_tdata;
  logic [DATA_WIDTH-1:0] data_m_tdata;
  logic [DATA_WIDTH-1:0] ctrl_s_tdata;
  logic [DATA_WIDTH-1:0] ctrl_m_tdata;
  logic [STRB_WIDTH-1:0] data_s_tkeep;
  logic [STRB_WIDTH-1:0] data_m_tkeep;
  logic                  data_s_tvalid;
  logic                  data_s_tready;
  logic                  data_s_tlast;
  logic                  data_m_tvalid;
  logic                  data_m_tready;
  logic                  data_m_tlast;
  logic                  ctrl_s_tvalid;
  logic                  ctrl_s_tready;
  logic                  ctrl_m_tvalid;
  logic                  ctrl_m_tready;
  logic [SLOT_WIDTH-1:0] data_s_tdest;
  logic [SLOT_WIDTH-1:0] data_m_tuser;
  logic [PORT_WIDTH-1:0] data_s_tuser;
  logic [PORT_WIDTH-1:0] data_m_tdest;

  integer     seed;
  integer     ready_seed;
  int         lens [NUM_PKTS];
  int         ports [NUM_PKTS];
  int         watch_cycles = 0;
  int         cycle_cnt = 0;
  logic [7:0] mem_model [int];
  beat_t      beat_q [$];
  desc_t      echo_q [$];
  desc_t      recv_q [$];
  desc_t      got_recv [$];
  beat_t      beat_head;
  desc_t      echo_head;
  desc_t      recv_head;
  logic       beat_ok = 1'b0;
  logic       echo_ok = 1'b0;
  logic       recv_ok = 1'b0;
  logic       data_xfer = 1'b0;
  logic       ctrl_xfer = 1'b0;
  desc_t      ctrl_word;

  slot_buffer_top #(.INTERLEAVE(1'b1)) dut (.*);

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) cycle_cnt <= cycle_cnt + 1;

  task automatic stop_on_error;
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first failed check");
  endtask

  function automatic logic [DATA_WIDTH-1:0] keep_mask(input logic [STRB_WIDTH-1:0] keep);
    logic [DATA_WIDTH-1:0] m;
    m = '0;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      m[b*8 +: 8] = {8{keep[b]}};
    end
    return m;
  endfunction

  // Final beat keeps len mod 8 bytes, a full line when that is zero
  function automatic logic [STRB_WIDTH-1:0] last_keep(input int len);
    int tail;
    tail = len % STRB_WIDTH;
    return (tail == 0) ? {STRB_WIDTH{1'b1}} : STRB_WIDTH'((1 << tail) - 1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks enter and leave 1 ns after a rising edge

  task automatic send_packet(input int pkt);
    int                    beats;
    int                    j;
    int                    slot;
    logic [STRB_WIDTH-1:0] keep;
    logic [DATA_WIDTH-1:0] data;
    desc_t                 d;
    logic                  taken;
    slot  = pkt % SLOT_COUNT;
    beats = (lens[pkt] + STRB_WIDTH - 1) / STRB_WIDTH;
    for (j = 0; j < beats; j++) begin
      keep = (j == beats - 1) ? last_keep(lens[pkt]) : {STRB_WIDTH{1'b1}};
      data = {$random(seed), $random(seed)};
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (keep[b]) begin
          mem_model[SLOT_START_ADDR + slot * SLOT_ADDR_STEP + STRB_WIDTH * j + b]
            = data[b*8 +: 8];
        end
      end
      data_s_tdata  = data;
      data_s_tkeep  = keep;
      data_s_tlast  = (j == beats - 1);
      data_s_tdest  = SLOT_WIDTH'(slot);
      data_s_tuser  = PORT_WIDTH'(ports[pkt]);
      data_s_tvalid = 1'b1;
      // Ready is sampled mid cycle, before the edge that takes the beat
      do begin
        @(negedge sys_clk);
        taken = data_s_tready;
        @(posedge sys_clk);
        #1;
      end while (!taken);
    end
    data_s_tvalid = 1'b0;
    d      = '0;
    d.addr = ADDR_WIDTH'(SLOT_START_ADDR + slot * SLOT_ADDR_STEP);
    d.port = PORT_WIDTH'(ports[pkt]);
    d.slot = SLOT_WIDTH'(slot);
    d.len  = LEN_WIDTH'(STRB_WIDTH * (beats - 1) + $countones(keep));
    recv_q.push_back(d);
  endtask

  task automatic ingress_group(input int first);
    for (int i = first; i < first + 4; i++) begin
      send_packet(i);
    end
  endtask

  // Each received descriptor goes back in as a send descriptor
  task automatic egress_group(input int count);
    desc_t d;
    beat_t e;
    int    lines;
    int    addr;
    logic  taken;
    for (int k = 0; k < count; k++) begin
      while (got_recv.size() == 0) begin
        @(posedge sys_clk);
        #1;
      end
      d     = got_recv.pop_front();
      lines = (int'(d.len) + STRB_WIDTH - 1) / STRB_WIDTH;
      for (int j = 0; j < lines; j++) begin
        e = '0;
        for (int b = 0; b < STRB_WIDTH; b++) begin
          addr = int'(d.addr) + STRB_WIDTH * j + b;
          if (mem_model.exists(addr)) e.data[b*8 +: 8] = mem_model[addr];
        end
        e.last = (j == lines - 1);
        e.keep = e.last ? last_keep(int'(d.len)) : {STRB_WIDTH{1'b1}};
        e.dest = d.port;
        e.user = d.slot;
        beat_q.push_back(e);
      end
      echo_q.push_back(d);
      ctrl_s_tdata  = d;
      ctrl_s_tvalid = 1'b1;
      do begin
        @(negedge sys_clk);
        taken = ctrl_s_tready;
        @(posedge sys_clk);
        #1;
      end while (!taken);
      ctrl_s_tvalid = 1'b0;
    end
  endtask

  task automatic wait_drain;
    @(posedge sys_clk);
    while (beat_q.size() != 0 || echo_q.size() != 0 || recv_q.size() != 0) begin
      @(posedge sys_clk);
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference queues are popped at transfers seen at the falling edge

  always @(posedge sys_clk) begin
    if (!sys_rst) begin
      if (data_xfer && beat_q.size() != 0) begin
        void'(beat_q.pop_front());
      end
      if (ctrl_xfer) begin
        if (echo_q.size() != 0 && ctrl_word == echo_q[0]) begin
          void'(echo_q.pop_front());
        end else if (recv_q.size() != 0 && ctrl_word == recv_q[0]) begin
          got_recv.push_back(recv_q.pop_front());
        end
      end
    end
  end

  always @(negedge sys_clk) begin
    beat_ok = (beat_q.size() != 0);
    echo_ok = (echo_q.size() != 0);
    recv_ok = (recv_q.size() != 0);
    beat_head = '0;
    echo_head = '0;
    recv_head = '0;
    if (beat_ok) beat_head = beat_q[0];
    if (echo_ok) echo_head = echo_q[0];
    if (recv_ok) recv_head = recv_q[0];
    data_xfer = data_m_tvalid && data_m_tready;
    ctrl_xfer = ctrl_m_tvalid && ctrl_m_tready;
    ctrl_word = ctrl_m_tdata;
  end

  assert property (@(posedge sys_clk) cycle_cnt > 0 && $past(sys_rst) |->
    !data_m_tvalid && !ctrl_m_tvalid)
    else begin
      $display("Output valid was high during reset or in the cycle after it");
      stop_on_error();
    end

  assert property (@(posedge sys_clk) disable iff (sys_rst)
    data_m_tvalid && data_m_tready |-> beat_ok)
    else begin
      $display("Beat transferred on data_m while no packet was expected");
      stop_on_error();
    end

  assert property (@(posedge sys_clk) disable iff (sys_rst)
    data_m_tvalid && data_m_tready && beat_ok |->
      (data_m_tdata & keep_mask(beat_head.keep)) == (beat_head.data & keep_mask(beat_head.keep))
      && data_m_tkeep == beat_head.keep && data_m_tlast == beat_head.last
      && data_m_tdest == beat_head.dest && data_m_tuser == beat_head.user)
    else begin
      $display("Error: loopback expected %h actual %h", beat_head,
        {$sampled(data_m_tdata) & keep_mask(beat_head.keep), $sampled(data_m_tkeep),
         $sampled(data_m_tlast), $sampled(data_m_tdest), $sampled(data_m_tuser)});
      stop_on_error();
    end

  assert property (@(posedge sys_clk) disable iff (sys_rst)
    data_m_tvalid && !data_m_tready |=> data_m_tvalid && $stable(data_m_tdata)
      && $stable(data_m_tkeep) && $stable(data_m_tlast))
    else begin
      $display("Stalled beat on data_m dropped or changed before it was taken");
      stop_on_error();
    end

  // Echo and receive words may interleave, each stream stays in order
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    ctrl_m_tvalid && ctrl_m_tready |->
      (echo_ok && ctrl_m_tdata == echo_head) || (recv_ok && ctrl_m_tdata == recv_head))
    else begin
      $display("Error: ctrl_desc expected %h (echo) or %h (receive) actual %h",
        echo_head, recv_head, $sampled(ctrl_m_tdata));
      stop_on_error();
    end

  ////////////////////////////////////////////////////////////////////////////
  // Back-pressure, watchdog and test sequence

  initial begin
    forever begin
      @(posedge sys_clk);
      #1;
      data_m_tready = ($random(ready_seed) % 4) != 0;
      ctrl_m_tready = ($random(ready_seed) % 4) != 0;
    end
  end

  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge sys_clk);
    $display("Watchdog ran out after %0d cycles, the DUT hung", watch_cycles);
    stop_on_error();
  end

  initial begin
    int total_beats;
    sys_rst       = 1'b1;
    data_s_tdata  = '0;
    data_s_tkeep  = '0;
    data_s_tvalid = 1'b0;
    data_s_tlast  = 1'b0;
    data_s_tdest  = '0;
    data_s_tuser  = '0;
    data_m_tready = 1'b1;
    ctrl_s_tdata  = '0;
    ctrl_s_tvalid = 1'b0;
    ctrl_m_tready = 1'b1;
    seed          = SEED;
    ready_seed    = SEED ^ 32'h5a5a;
    total_beats   = 0;
    for (int i = 0; i < NUM_PKTS; i++) begin
      lens[i]  = 1 + ({$random(seed)} % 200);
      ports[i] = {$random(seed)} % 4;
    end
    // Whole lines and a single byte
    lens[0] = 64;
    lens[1] = 1;
    for (int i = 0; i < NUM_PKTS; i++) begin
      total_beats += 2 * ((lens[i] + STRB_WIDTH - 1) / STRB_WIDTH);
    end
    watch_cycles = total_beats * 20 + 2000;
    repeat (3) @(posedge sys_clk);
    #1 sys_rst = 1'b0;
    @(posedge sys_clk);
    #1;
    ingress_group(0);
    // Slots 0 to 3 drain while slots 4 to 7 fill
    fork
      ingress_group(4);
      egress_group(4);
    join
    wait_drain();
    fork
      ingress_group(8);
      egress_group(4);
    join
    wait_drain();
    egress_group(4);
    wait_drain();
    repeat (10) @(posedge sys_clk);
    if (beat_q.size() == 0 && echo_q.size() == 0 && recv_q.size() == 0
        && got_recv.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Reference queues still hold entries at the end of the run");
      stop_on_error();
    end
  end

endmodule

// File: compile.f
source/slot_buffer_pkg.sv
source/mem_port_if.sv
source/desc_fifo.sv
source/ingress_writer.sv
source/egress_reader.sv
source/packet_mem.sv
source/ctrl_port.sv
source/slot_buffer_top.sv
testbench/tb_slot_buffer.sv

// File: Bender.yml
package:
  name: slot_buffer

sources:
  - source/slot_buffer_pkg.sv
  - source/mem_port_if.sv
  - source/desc_fifo.sv
  - source/ingress_writer.sv
  - source/egress_reader.sv
  - source/packet_mem.sv
  - source/ctrl_port.sv
  - source/slot_buffer_top.sv
  - target: simulation
    files:
      - testbench/tb_slot_buffer.sv
